//--- Makefile
# Verilator build and run for the data cache testbench
TOP = dcache_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^Simulation passed$$" sim.log

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- compile.f
verilog/dcache_pkg.sv
verilog/dcache_ctrl.sv
verilog/word_memory.sv
verilog/dcache_top.sv
dv/dcache_sva.sv
dv/dcache_tb.sv

//--- dv/dcache_sva.sv
// Bus and halt assertions for dcache_ctrl; needs the controller's internal state signal bound in
`timescale 1ns/1ps

module dcache_sva (
	input logic                 CLK,
	input logic                 nRST,
	input dcache_pkg::dp_req_t  dp_req_i,
	input logic                 mem_wait_i,
	input logic                 dhit_o,
	input logic                 flushed_o,
	input dcache_pkg::mem_req_t mem_req_o,
	input dcache_pkg::dstate_t  state
);
	import dcache_pkg::*;

	logic halting;

	assign halting = state inside {CLEAN, FLUSH1, FLUSH2, HLT_CNT, HALTED};

	a_one_direction: assert property (@(posedge CLK) disable iff (!nRST)
		!(mem_req_o.ren && mem_req_o.wen))
		else $error("memory ren and wen high together");

	// Memory counts its wait only while the request holds still
	a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
		mem_wait_i |=> $stable(mem_req_o))
		else $error("memory request changed while wait was high");

	a_flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
		flushed_o |=> flushed_o)
		else $error("flushed fell after it had risen");

	// Once halt is taken in IDLE the cache never serves again
	a_no_hit_halt: assert property (@(posedge CLK) disable iff (!nRST)
		(halting || (state == IDLE && dp_req_i.halt)) |=> (halting && !dhit_o))
		else $error("hit reported or service resumed after halt");

endmodule

//--- dv/dcache_tb.sv
// Random word reads and writes in a 256-byte window at 0x400, then halt; checked against a model
`timescale 1ns/1ps

module dcache_tb;
	import dcache_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int NREQ = 300;
	localparam word_t BASE = 32'h0000_0400;
	localparam int WIN_WORDS = 64;
	// Dirty miss is the worst case, four accesses plus the IDLE cycles around them
	localparam int REQ_CYCLES = 4 * (MEM_WAIT + 1) + 2;
	localparam int FLUSH_CYCLES = SETS * (4 * (MEM_WAIT + 1) + 3) + (MEM_WAIT + 1) + 2;
	localparam int LIMIT_CYCLES = (NREQ + 1) * REQ_CYCLES + FLUSH_CYCLES + WIN_WORDS + 40;

	logic CLK;
	logic nRST;
	dp_req_t dp_req;
	word_t peek_addr;
	logic dhit;
	word_t load;
	logic flushed;
	word_t peek_data;

	logic [31:0] lfsr;
	word_t model_mem [WIN_WORDS];
	logic [TAG_W-1:0] sh_tag [SETS][2];
	logic sh_valid [SETS][2];
	logic sh_lru [SETS];
	int hits;
	int misses;

	dcache_top dut (
		.CLK         (CLK),
		.nRST        (nRST),
		.dp_req_i    (dp_req),
		.peek_addr_i (peek_addr),
		.dhit_o      (dhit),
		.load_o      (load),
		.flushed_o   (flushed),
		.peek_data_o (peek_data)
	);

	bind dcache_ctrl dcache_sva u_sva (
		.CLK        (CLK),
		.nRST       (nRST),
		.dp_req_i   (dp_req_i),
		.mem_wait_i (mem_wait_i),
		.dhit_o     (dhit_o),
		.flushed_o  (flushed_o),
		.mem_req_o  (mem_req_o),
		.state      (state)
	);

	initial
	begin
		CLK = 1'b0;
		forever
			#(CLK_PERIOD / 2) CLK = ~CLK;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic int win_index(input word_t addr);
		return int'((addr - BASE) >> 2);
	endfunction

	task automatic check_eq(input word_t got, input word_t exp, input string what);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t ns: %s, got %h expected %h",
				$time, what, got, exp);
			$display("Simulation failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	function automatic logic shadow_hit(input word_t addr);
		daddr_t d;
		d = daddr_t'(addr);
		return (sh_valid[d.idx][0] && sh_tag[d.idx][0] == d.tag)
			|| (sh_valid[d.idx][1] && sh_tag[d.idx][1] == d.tag);
	endfunction

	// Hit or fill, the LRU bit ends up pointing at the other way
	task automatic shadow_touch(input word_t addr);
		daddr_t d;
		logic way;
		d = daddr_t'(addr);
		if (sh_valid[d.idx][0] && sh_tag[d.idx][0] == d.tag)
			way = 1'b0;
		else if (sh_valid[d.idx][1] && sh_tag[d.idx][1] == d.tag)
			way = 1'b1;
		else
		begin
			way = sh_lru[d.idx];
			sh_valid[d.idx][way] = 1'b1;
			sh_tag[d.idx][way] = d.tag;
		end
		sh_lru[d.idx] = ~way;
	endtask

	// Called on the first cycle of a held request
	task automatic await_accept(input logic wr, input word_t addr, input word_t data,
		input logic exp_hit);
		check_eq(word_t'(dhit), word_t'(exp_hit), $sformatf("first-cycle hit at %h", addr));
		if (!exp_hit)
			misses++;
		while (!dhit)
			@(negedge CLK);
		hits++;
		if (wr)
			model_mem[win_index(addr)] = data;
		else
			check_eq(load, model_mem[win_index(addr)], $sformatf("read data at %h", addr));
		shadow_touch(addr);
	endtask

	task automatic run_request(input logic wr, input word_t addr, input word_t data);
		dp_req_t r;
		logic exp_hit;
		exp_hit = shadow_hit(addr);
		r = '0;
		r.ren = !wr;
		r.wen = wr;
		r.addr = addr;
		r.store = data;
		@(posedge CLK);
		dp_req <= r;
		@(negedge CLK);
		await_accept(wr, addr, data, exp_hit);
	endtask

	initial
	begin
		logic wr;
		word_t addr;
		word_t data;
		dp_req_t hreq;
		dp_req_t rst_req;
		// Read held through reset, it must not hit on cleared frames
		rst_req = '0;
		rst_req.ren = 1'b1;
		rst_req.addr = BASE;
		lfsr = 32'hd5c9;
		nRST = 1'b0;
		dp_req = rst_req;
		peek_addr = '0;
		hits = 0;
		misses = 0;
		for (int i = 0; i < WIN_WORDS; i++)
			model_mem[i] = '0;
		for (int s = 0; s < SETS; s++)
		begin
			sh_lru[s] = 1'b0;
			sh_valid[s][0] = 1'b0;
			sh_valid[s][1] = 1'b0;
			sh_tag[s][0] = '0;
			sh_tag[s][1] = '0;
		end

		repeat (10)
		begin
			@(negedge CLK);
			check_eq(word_t'(dhit), '0, "dhit in reset");
			check_eq(word_t'(flushed), '0, "flushed in reset");
		end
		@(posedge CLK);
		nRST <= 1'b1;
		@(negedge CLK);
		check_eq(word_t'(flushed), '0, "flushed after reset");
		// The held read becomes the first request, a miss on the empty cache
		await_accept(1'b0, BASE, '0, shadow_hit(BASE));

		// Four tags over eight sets keep conflicts and evictions frequent
		for (int n = 0; n < NREQ; n++)
		begin
			wr = take_bits(1) != 0;
			addr = BASE + (take_bits(2) << 6);
			addr = addr + (take_bits(3) << 3);
			addr = addr + (take_bits(1) << 2);
			data = take_bits(32);
			run_request(wr, addr, data);
		end

		hreq = '0;
		hreq.halt = 1'b1;
		@(posedge CLK);
		dp_req <= hreq;
		@(negedge CLK);
		while (!flushed)
			@(negedge CLK);

		for (int i = 0; i < WIN_WORDS; i++)
		begin
			@(posedge CLK);
			peek_addr <= BASE + word_t'(i * 4);
			@(negedge CLK);
			check_eq(peek_data, model_mem[i], $sformatf("memory word %0d after flush", i));
		end
		@(posedge CLK);
		peek_addr <= CNT_ADDR;
		@(negedge CLK);
		check_eq(peek_data, word_t'(hits - misses), "hit counter");

		$display("Simulation passed");
		$finish;
	end

	initial
	begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- verilog/dcache_ctrl.sv
// 2-way write-back data cache; requests must be held until dhit_o, halt is final and not undone
`timescale 1ns/1ps

module dcache_ctrl (
	input  logic                 CLK,
	input  logic                 nRST,
	input  dcache_pkg::dp_req_t  dp_req_i,
	input  logic                 mem_wait_i,
	input  dcache_pkg::word_t    mem_load_i,
	output logic                 dhit_o,
	output dcache_pkg::word_t    load_o,
	output logic                 flushed_o,
	output dcache_pkg::mem_req_t mem_req_o
);
	import dcache_pkg::*;

	dstate_t state, next_state;
	frame_t frm [SETS][2];
	logic lru [SETS];
	logic [IDX_W:0] flush_idx, next_flush_idx;
	word_t hit_cnt, next_hit_cnt;

	daddr_t a;
	logic [IDX_W-1:0] fset;
	logic [1:0] match;
	logic hit_way, vic_way, fl_way;
	logic req_any, serving;
	frame_t vic, fl_frm;

	// Single frame write port
	logic frm_we;
	logic [IDX_W-1:0] frm_set;
	logic frm_way;
	frame_t next_frame;
	logic lru_we, next_lru_bit;

	assign a = daddr_t'(dp_req_i.addr);
	assign fset = flush_idx[IDX_W-1:0];
	assign req_any = dp_req_i.ren | dp_req_i.wen;
	assign serving = (state == IDLE) && !dp_req_i.halt;

	assign match[0] = frm[a.idx][0].valid && (frm[a.idx][0].tag == a.tag);
	assign match[1] = frm[a.idx][1].valid && (frm[a.idx][1].tag == a.tag);
	assign hit_way = !match[0];

	// LRU bit names the way to replace
	assign vic_way = lru[a.idx];
	assign vic = frm[a.idx][vic_way];

	// Way 0 is flushed first when both are dirty
	assign fl_way = !frm[fset][0].dirty;
	assign fl_frm = frm[fset][fl_way];

	assign dhit_o = serving && req_any && (|match);
	assign load_o = frm[a.idx][hit_way].data[a.blkoff];
	assign flushed_o = (state == HALTED);

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			state <= IDLE;
			flush_idx <= '0;
			hit_cnt <= '0;
			for (int s = 0; s < SETS; s++)
			begin
				lru[s] <= 1'b0;
				for (int w = 0; w < 2; w++)
				begin
					frm[s][w].valid <= 1'b0;
					frm[s][w].dirty <= 1'b0;
				end
			end
		end
		else
		begin
			state <= next_state;
			flush_idx <= next_flush_idx;
			hit_cnt <= next_hit_cnt;
			if (lru_we)
				lru[a.idx] <= next_lru_bit;
			if (frm_we)
				frm[frm_set][frm_way] <= next_frame;
		end
	end

	always_comb
	begin
		next_state = state;
		next_flush_idx = flush_idx;
		next_hit_cnt = hit_cnt;
		mem_req_o = '0;
		frm_we = 1'b0;
		frm_set = a.idx;
		frm_way = vic_way;
		next_frame = vic;
		lru_we = 1'b0;
		next_lru_bit = ~hit_way;

		case (state)
			IDLE:
			begin
				if (dp_req_i.halt)
					next_state = CLEAN;
				else if (dhit_o)
				begin
					next_hit_cnt = hit_cnt + 1;
					lru_we = 1'b1;
					if (dp_req_i.wen)
					begin
						frm_we = 1'b1;
						frm_way = hit_way;
						next_frame = frm[a.idx][hit_way];
						next_frame.dirty = 1'b1;
						next_frame.data[a.blkoff] = dp_req_i.store;
					end
				end
				else if (req_any)
				begin
					next_hit_cnt = hit_cnt - 1;
					next_state = vic.dirty ? WB1 : LD1;
				end
			end
			LD1:
			begin
				mem_req_o.ren = 1'b1;
				mem_req_o.addr = {a.tag, a.idx, 3'b000};
				if (!mem_wait_i)
				begin
					// Frame stays invalid until the second word is in
					frm_we = 1'b1;
					next_frame.valid = 1'b0;
					next_frame.dirty = 1'b0;
					next_frame.tag = a.tag;
					next_frame.data[0] = mem_load_i;
					next_state = LD2;
				end
			end
			LD2:
			begin
				mem_req_o.ren = 1'b1;
				mem_req_o.addr = {a.tag, a.idx, 3'b100};
				if (!mem_wait_i)
				begin
					frm_we = 1'b1;
					next_frame.valid = 1'b1;
					next_frame.data[1] = mem_load_i;
					next_state = IDLE;
				end
			end
			WB1:
			begin
				mem_req_o.wen = 1'b1;
				mem_req_o.addr = {vic.tag, a.idx, 3'b000};
				mem_req_o.store = vic.data[0];
				if (!mem_wait_i)
					next_state = WB2;
			end
			WB2:
			begin
				mem_req_o.wen = 1'b1;
				mem_req_o.addr = {vic.tag, a.idx, 3'b100};
				mem_req_o.store = vic.data[1];
				if (!mem_wait_i)
					next_state = LD1;
			end
			CLEAN:
			begin
				if (flush_idx[IDX_W])
					next_state = HLT_CNT;
				else if (frm[fset][0].dirty || frm[fset][1].dirty)
					next_state = FLUSH1;
				else
					next_flush_idx = flush_idx + 1'b1;
			end
			FLUSH1:
			begin
				mem_req_o.wen = 1'b1;
				mem_req_o.addr = {fl_frm.tag, fset, 3'b000};
				mem_req_o.store = fl_frm.data[0];
				if (!mem_wait_i)
					next_state = FLUSH2;
			end
			FLUSH2:
			begin
				mem_req_o.wen = 1'b1;
				mem_req_o.addr = {fl_frm.tag, fset, 3'b100};
				mem_req_o.store = fl_frm.data[1];
				if (!mem_wait_i)
				begin
					// Back to CLEAN for the same set, the other way may be dirty too
					frm_we = 1'b1;
					frm_set = fset;
					frm_way = fl_way;
					next_frame = fl_frm;
					next_frame.dirty = 1'b0;
					next_state = CLEAN;
				end
			end
			HLT_CNT:
			begin
				mem_req_o.wen = 1'b1;
				mem_req_o.addr = CNT_ADDR;
				mem_req_o.store = hit_cnt;
				if (!mem_wait_i)
					next_state = HALTED;
			end
			HALTED:
			begin
				next_state = HALTED;
			end
			default:
			begin
				next_state = IDLE;
			end
		endcase
	end

endmodule

//--- verilog/dcache_pkg.sv
// Shared types for the data cache; 32-bit byte addresses, two-word blocks, word accesses only
package dcache_pkg;

	localparam int WORD_W = 32;
	localparam int SETS = 8;
	localparam int IDX_W = 3;
	localparam int TAG_W = 26;

	// Backing store size and per-access latency
	localparam int MEM_WORDS = 16384;
	localparam int MEM_AW = $clog2(MEM_WORDS);
	localparam int MEM_WAIT = 2;
	localparam int MEM_CW = $clog2(MEM_WAIT + 2);

	typedef logic [WORD_W-1:0] word_t;

	// Hit counter lands here on halt
	localparam word_t CNT_ADDR = 32'h0000_3100;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [IDX_W-1:0] idx;
		logic             blkoff;
		logic [1:0]       byteoff;
	} daddr_t;

	typedef struct packed {
		logic             valid;
		logic             dirty;
		logic [TAG_W-1:0] tag;
		word_t [1:0]      data;
	} frame_t;

	typedef enum logic [3:0] {
		IDLE, LD1, LD2, WB1, WB2, CLEAN, FLUSH1, FLUSH2, HLT_CNT, HALTED
	} dstate_t;

	typedef struct packed {
		logic  ren;
		logic  wen;
		logic  halt;
		word_t addr;
		word_t store;
	} dp_req_t;

	typedef struct packed {
		logic  ren;
		logic  wen;
		word_t addr;
		word_t store;
	} mem_req_t;

endpackage

//--- verilog/dcache_top.sv
// Data cache joined to its backing memory; the peek port reads memory only, never the cache
`timescale 1ns/1ps

module dcache_top (
	input  logic                CLK,
	input  logic                nRST,
	input  dcache_pkg::dp_req_t dp_req_i,
	input  dcache_pkg::word_t   peek_addr_i,
	output logic                dhit_o,
	output dcache_pkg::word_t   load_o,
	output logic                flushed_o,
	output dcache_pkg::word_t   peek_data_o
);
	import dcache_pkg::*;

	mem_req_t mem_req;
	logic mem_wait;
	word_t mem_load;

	dcache_ctrl u_dcache (
		.CLK        (CLK),
		.nRST       (nRST),
		.dp_req_i   (dp_req_i),
		.mem_wait_i (mem_wait),
		.mem_load_i (mem_load),
		.dhit_o     (dhit_o),
		.load_o     (load_o),
		.flushed_o  (flushed_o),
		.mem_req_o  (mem_req)
	);

	word_memory u_mem (
		.CLK         (CLK),
		.nRST        (nRST),
		.req_i       (mem_req),
		.peek_addr_i (peek_addr_i),
		.wait_o      (mem_wait),
		.load_o      (mem_load),
		.peek_data_o (peek_data_o)
	);

endmodule

//--- verilog/word_memory.sv
// Word memory with fixed wait; address bits above MEM_AW+1 are ignored, low two bits too
`timescale 1ns/1ps

module word_memory (
	input  logic                 CLK,
	input  logic                 nRST,
	input  dcache_pkg::mem_req_t req_i,
	input  dcache_pkg::word_t    peek_addr_i,
	output logic                 wait_o,
	output dcache_pkg::word_t    load_o,
	output dcache_pkg::word_t    peek_data_o
);
	import dcache_pkg::*;

	word_t mem [MEM_WORDS] = '{default: '0};

	logic [MEM_CW-1:0] cnt, cnt_eff, next_cnt;
	word_t last_addr;
	logic last_ren, last_wen;
	logic active, changed;

	assign active = req_i.ren | req_i.wen;

	// Any change of address or direction starts the count over
	assign changed = (req_i.addr != last_addr) || (req_i.ren != last_ren)
		|| (req_i.wen != last_wen);
	assign cnt_eff = changed ? '0 : cnt;

	assign wait_o = active && (cnt_eff != MEM_CW'(MEM_WAIT));

	always_comb
	begin
		if (!active || !wait_o)
			next_cnt = '0;
		else
			next_cnt = cnt_eff + 1'b1;
	end

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			cnt <= '0;
			last_addr <= '0;
			last_ren <= 1'b0;
			last_wen <= 1'b0;
		end
		else
		begin
			cnt <= next_cnt;
			last_addr <= req_i.addr;
			last_ren <= req_i.ren;
			last_wen <= req_i.wen;
		end
	end

	// Write commits at the edge closing the completing cycle
	always_ff @(posedge CLK)
	begin
		if (req_i.wen && !wait_o)
			mem[req_i.addr[MEM_AW+1:2]] <= req_i.store;
	end

	assign load_o = mem[req_i.addr[MEM_AW+1:2]];
	assign peek_data_o = mem[peek_addr_i[MEM_AW+1:2]];

endmodule
